/* design/hello_config.svh */
// Register addresses, control and status bit positions, bus and counter widths
`ifndef HELLO_CONFIG_SVH
`define HELLO_CONFIG_SVH

// ----------------------------------------------------------------------
// Bus and datapath widths
// ----------------------------------------------------------------------
`define OCL_ADDR_W 32
`define OCL_DATA_W 32
`define VLED_W     16
`define CNT_W      16
`define TICK_W     8

// ----------------------------------------------------------------------
// Register map
// ----------------------------------------------------------------------
`define HELLO_WORLD_REG_ADDR 32'h0000_0500
`define VLED_REG_ADDR        32'h0000_0504
`define CNT_CTRL_REG_ADDR    32'h0000_0508
`define TICK_VALUE_REG_ADDR  32'h0000_050C
`define LOAD_VALUE_REG_ADDR  32'h0000_0510
`define WATERMARK_REG_ADDR   32'h0000_0514
`define CNT_STATUS_REG_ADDR  32'h0000_0518

// Word returned for any address outside the map
`define UNIMPLEMENTED_REG_VALUE 32'hDEAD_BEEF

// Counter control bits, load and clear are one-cycle pulses
`define CTRL_ENABLE_BIT  0
`define CTRL_ONESHOT_BIT 1
`define CTRL_LOAD_BIT    2
`define CTRL_CLEAR_BIT   3

// Counter status layout, cnt sits in the low bits
`define STATUS_TICK_CNT_LSB 16
`define STATUS_TICK_BIT     24
`define STATUS_GE_WM_BIT    25

`endif

/* design/ocl_bus_pkg.sv */
// Bus address and data types, access FSM state encoding
`default_nettype none

package ocl_bus_pkg;

`include "hello_config.svh"

  // Byte address as seen on the AW and AR channels
  typedef logic [`OCL_ADDR_W-1:0] ocl_addr_t;

  // Single-beat data word, W and R channels
  typedef logic [`OCL_DATA_W-1:0] ocl_data_t;

  // One access in flight at a time
  typedef enum logic [2:0] {
    ACC_IDLE     = 3'd0,
    // Address taken, waiting for write data
    ACC_WR_DATA  = 3'd1,
    ACC_WR_RESP  = 3'd2,
    // One cycle to sample the read mux
    ACC_RD_FETCH = 3'd3,
    ACC_RD_RESP  = 3'd4
  } access_state_t;

endpackage

`default_nettype wire

/* design/hello_regs_pkg.sv */
// LED vector, main counter and prescaler types
`default_nettype none

package hello_regs_pkg;

`include "hello_config.svh"

  // Virtual LED or DIP switch bank
  typedef logic [`VLED_W-1:0] vled_t;

  // Main event counter value
  typedef logic [`CNT_W-1:0] cnt_t;

  // Prescaler count and compare value
  typedef logic [`TICK_W-1:0] tick_t;

endpackage

`default_nettype wire

/* design/ocl_access_fsm.sv */
// Single-beat AXI-Lite slave FSM, write and read handshakes, register port
`timescale 1ns/1ps
`default_nettype none

module ocl_access_fsm (
  input  logic                   clk_main_a0,
  input  logic                   rst_main_n_sync,
  // Write address
  input  logic                   awvalid,
  input  ocl_bus_pkg::ocl_addr_t awaddr,
  output logic                   awready,
  // Write data
  input  logic                   wvalid,
  input  ocl_bus_pkg::ocl_data_t wdata,
  output logic                   wready,
  // Write response
  input  logic                   bready,
  output logic                   bvalid,
  // Read address
  input  logic                   arvalid,
  input  ocl_bus_pkg::ocl_addr_t araddr,
  output logic                   arready,
  // Read data
  input  logic                   rready,
  output logic                   rvalid,
  output ocl_bus_pkg::ocl_data_t rdata,
  // Register file side
  output logic                   reg_wr_en,
  output ocl_bus_pkg::ocl_addr_t reg_wr_addr,
  output ocl_bus_pkg::ocl_data_t reg_wr_data,
  output ocl_bus_pkg::ocl_addr_t reg_rd_addr,
  input  ocl_bus_pkg::ocl_data_t reg_rd_data
);

  import ocl_bus_pkg::*;

  access_state_t state_q;
  access_state_t state_d;
  // Address of the access in flight, shared by writes and reads
  ocl_addr_t     addr_q;

  // ----------------------------------------------------------------------
  // Next state
  // ----------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      // Write wins when both address channels are valid
      ACC_IDLE: begin
        if (awvalid) begin
          state_d = ACC_WR_DATA;
        end else if (arvalid) begin
          state_d = ACC_RD_FETCH;
        end
      end
      ACC_WR_DATA: begin
        if (wvalid) begin
          state_d = ACC_WR_RESP;
        end
      end
      ACC_WR_RESP: begin
        if (bready) begin
          state_d = ACC_IDLE;
        end
      end
      ACC_RD_FETCH: begin
        state_d = ACC_RD_RESP;
      end
      ACC_RD_RESP: begin
        if (rready) begin
          state_d = ACC_IDLE;
        end
      end
      default: begin
        state_d = ACC_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      state_q <= ACC_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Address capture on the AW or AR edge
  always_ff @(posedge clk_main_a0) begin
    if (state_q == ACC_IDLE) begin
      if (awvalid) begin
        addr_q <= awaddr;
      end else if (arvalid) begin
        addr_q <= araddr;
      end
    end
  end

  // Read data held from fetch until the R handshake
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rdata <= '0;
    end else if (state_q == ACC_RD_FETCH) begin
      rdata <= reg_rd_data;
    end
  end

  // ----------------------------------------------------------------------
  // Handshake outputs
  // ----------------------------------------------------------------------
  assign awready = (state_q == ACC_IDLE);
  assign arready = (state_q == ACC_IDLE) && !awvalid;
  // Level follows wvalid in the data phase
  assign wready  = (state_q == ACC_WR_DATA) && wvalid;
  assign bvalid  = (state_q == ACC_WR_RESP);
  assign rvalid  = (state_q == ACC_RD_RESP);

  // Register write happens on the W edge
  assign reg_wr_en   = wready;
  assign reg_wr_addr = addr_q;
  assign reg_wr_data = wdata;
  assign reg_rd_addr = addr_q;

  // Write and read responses never overlap
  a_resp_exclusive: assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    !(bvalid && rvalid)
  );

  // Read data held under back-pressure
  a_rdata_stable: assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (rvalid && !rready) |=> (rvalid && $stable(rdata))
  );

endmodule

`default_nettype wire

/* design/hello_reg_file.sv */
// Hello world and counter settings registers, load and clear pulses, read mux
`timescale 1ns/1ps
`default_nettype none

`include "hello_config.svh"

module hello_reg_file (
  input  logic                     clk_main_a0,
  input  logic                     rst_main_n_sync,
  // Write and read ports from the access FSM
  input  logic                     reg_wr_en,
  input  ocl_bus_pkg::ocl_addr_t   reg_wr_addr,
  input  ocl_bus_pkg::ocl_data_t   reg_wr_data,
  input  ocl_bus_pkg::ocl_addr_t   reg_rd_addr,
  output ocl_bus_pkg::ocl_data_t   reg_rd_data,
  // Counter controls
  output logic                     cnt_enable,
  output logic                     cnt_oneshot,
  output logic                     cnt_load,
  output logic                     cnt_clear,
  output hello_regs_pkg::tick_t    tick_value,
  output hello_regs_pkg::cnt_t     load_value,
  output hello_regs_pkg::cnt_t     watermark,
  // Counter status
  input  hello_regs_pkg::cnt_t     cnt,
  input  hello_regs_pkg::tick_t    tick_cnt,
  input  logic                     tick,
  input  logic                     cnt_ge_watermark,
  // LED path
  output hello_regs_pkg::vled_t    hello_low,
  input  hello_regs_pkg::vled_t    vled_q
);

  import ocl_bus_pkg::*;
  import hello_regs_pkg::*;

  ocl_data_t hello_q;
  ocl_data_t hello_swapped;
  ocl_data_t status_word;

  // Write decode
  logic wr_hello;
  logic wr_ctrl;
  logic wr_tick;
  logic wr_load;
  logic wr_wm;

  assign wr_hello = reg_wr_en && (reg_wr_addr == `HELLO_WORLD_REG_ADDR);
  assign wr_ctrl  = reg_wr_en && (reg_wr_addr == `CNT_CTRL_REG_ADDR);
  assign wr_tick  = reg_wr_en && (reg_wr_addr == `TICK_VALUE_REG_ADDR);
  assign wr_load  = reg_wr_en && (reg_wr_addr == `LOAD_VALUE_REG_ADDR);
  assign wr_wm    = reg_wr_en && (reg_wr_addr == `WATERMARK_REG_ADDR);

  // ----------------------------------------------------------------------
  // Hello world register
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      hello_q <= '0;
    end else if (wr_hello) begin
      hello_q <= reg_wr_data;
    end
  end

  // Reads come back byte reversed
  assign hello_swapped = {hello_q[7:0], hello_q[15:8], hello_q[23:16], hello_q[31:24]};
  assign hello_low     = hello_q[`VLED_W-1:0];

  // ----------------------------------------------------------------------
  // Counter settings
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      cnt_enable  <= 1'b0;
      cnt_oneshot <= 1'b0;
      tick_value  <= '0;
      load_value  <= '0;
      watermark   <= '0;
    end else begin
      if (wr_ctrl) begin
        cnt_enable  <= reg_wr_data[`CTRL_ENABLE_BIT];
        cnt_oneshot <= reg_wr_data[`CTRL_ONESHOT_BIT];
      end
      if (wr_tick) begin
        tick_value <= reg_wr_data[`TICK_W-1:0];
      end
      if (wr_load) begin
        load_value <= reg_wr_data[`CNT_W-1:0];
      end
      if (wr_wm) begin
        watermark <= reg_wr_data[`CNT_W-1:0];
      end
    end
  end

  // Load and clear self-clear after one cycle
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      cnt_load  <= 1'b0;
      cnt_clear <= 1'b0;
    end else begin
      cnt_load  <= wr_ctrl && reg_wr_data[`CTRL_LOAD_BIT];
      cnt_clear <= wr_ctrl && reg_wr_data[`CTRL_CLEAR_BIT];
    end
  end

  // ----------------------------------------------------------------------
  // Read mux
  // ----------------------------------------------------------------------
  // Status packing, upper bits zero
  always_comb begin
    status_word                                       = '0;
    status_word[`CNT_W-1:0]                           = cnt;
    status_word[`STATUS_TICK_CNT_LSB +: `TICK_W]      = tick_cnt;
    status_word[`STATUS_TICK_BIT]                     = tick;
    status_word[`STATUS_GE_WM_BIT]                    = cnt_ge_watermark;
  end

  always_comb begin
    reg_rd_data = '0;
    case (reg_rd_addr)
      `HELLO_WORLD_REG_ADDR: reg_rd_data = hello_swapped;
      `VLED_REG_ADDR:        reg_rd_data[`VLED_W-1:0] = vled_q;
      // Pulse bits read as zero
      `CNT_CTRL_REG_ADDR: begin
        reg_rd_data[`CTRL_ENABLE_BIT]  = cnt_enable;
        reg_rd_data[`CTRL_ONESHOT_BIT] = cnt_oneshot;
      end
      `TICK_VALUE_REG_ADDR:  reg_rd_data[`TICK_W-1:0] = tick_value;
      `LOAD_VALUE_REG_ADDR:  reg_rd_data[`CNT_W-1:0]  = load_value;
      `WATERMARK_REG_ADDR:   reg_rd_data[`CNT_W-1:0]  = watermark;
      `CNT_STATUS_REG_ADDR:  reg_rd_data = status_word;
      default:               reg_rd_data = `UNIMPLEMENTED_REG_VALUE;
    endcase
  end

endmodule

`default_nettype wire

/* design/event_counter.sv */
// Tick prescaler, 16-bit event counter with load, clear, one-shot, watermark
`timescale 1ns/1ps
`default_nettype none

module event_counter (
  input  logic                  clk_main_a0,
  input  logic                  rst_main_n_sync,
  input  logic                  cnt_enable,
  input  logic                  cnt_oneshot,
  input  logic                  cnt_load,
  input  logic                  cnt_clear,
  input  hello_regs_pkg::tick_t tick_value,
  input  hello_regs_pkg::cnt_t  load_value,
  input  hello_regs_pkg::cnt_t  watermark,
  output hello_regs_pkg::cnt_t  cnt,
  output hello_regs_pkg::tick_t tick_cnt,
  output logic                  tick,
  output logic                  cnt_ge_watermark
);

  import hello_regs_pkg::*;

  // Prescaler has reached its compare value
  assign tick = (tick_cnt >= tick_value);

  // Clear beats load, load beats counting
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      cnt      <= '0;
      tick_cnt <= '0;
    end else if (cnt_clear) begin
      cnt      <= '0;
      tick_cnt <= '0;
    end else if (cnt_load) begin
      cnt <= load_value;
    end else if (cnt_enable) begin
      if (tick) begin
        tick_cnt <= '0;
        // Saturate at all ones in one-shot mode
        if (!(cnt_oneshot && (cnt == '1))) begin
          cnt <= cnt + 1'b1;
        end
      end else begin
        tick_cnt <= tick_cnt + 1'b1;
      end
    end
  end

  assign cnt_ge_watermark = (cnt >= watermark);

  // One-shot never rolls over
  a_oneshot_no_wrap: assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (cnt_oneshot && (cnt == '1) && !cnt_clear && !cnt_load) |=> (cnt != '0)
  );

endmodule

`default_nettype wire

/* design/vled_mask.sv */
// Virtual LED shadow, DIP switch synchronizer, masked LED output
`timescale 1ns/1ps
`default_nettype none

module vled_mask (
  input  logic                  clk_main_a0,
  input  logic                  rst_main_n_sync,
  input  hello_regs_pkg::vled_t hello_low,
  input  hello_regs_pkg::vled_t status_vdip,
  output hello_regs_pkg::vled_t vled_q,
  output hello_regs_pkg::vled_t status_vled
);

  import hello_regs_pkg::*;

  // Two-flop synchronizer for the DIP switches
  vled_t vdip_q;
  vled_t vdip_q2;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vled_q      <= '0;
      vdip_q      <= '0;
      vdip_q2     <= '0;
      status_vled <= '0;
    end else begin
      // LEDs shadow the low half of hello world
      vled_q      <= hello_low;
      vdip_q      <= status_vdip;
      vdip_q2     <= vdip_q;
      // Switch off means LED dark
      status_vled <= vled_q & vdip_q2;
    end
  end

endmodule

`default_nettype wire

/* design/cl_hello_top.sv */
// Top level with access FSM, register file, event counter and LED path
`timescale 1ns/1ps
`default_nettype none

module cl_hello_top (
  input  logic                     clk_main_a0,
  input  logic                     rst_main_n_sync,
  input  logic                     awvalid,
  input  ocl_bus_pkg::ocl_addr_t   awaddr,
  output logic                     awready,
  input  logic                     wvalid,
  input  ocl_bus_pkg::ocl_data_t   wdata,
  output logic                     wready,
  input  logic                     bready,
  output logic                     bvalid,
  input  logic                     arvalid,
  input  ocl_bus_pkg::ocl_addr_t   araddr,
  output logic                     arready,
  input  logic                     rready,
  output logic                     rvalid,
  output ocl_bus_pkg::ocl_data_t   rdata,
  input  hello_regs_pkg::vled_t    status_vdip,
  output hello_regs_pkg::vled_t    status_vled
);

  import ocl_bus_pkg::*;
  import hello_regs_pkg::*;

  // ----------------------------------------------------------------------
  // Internal nets
  // ----------------------------------------------------------------------
  logic      reg_wr_en;
  ocl_addr_t reg_wr_addr;
  ocl_data_t reg_wr_data;
  ocl_addr_t reg_rd_addr;
  ocl_data_t reg_rd_data;
  // Counter controls and status
  logic      cnt_enable;
  logic      cnt_oneshot;
  logic      cnt_load;
  logic      cnt_clear;
  tick_t     tick_value;
  cnt_t      load_value;
  cnt_t      watermark;
  cnt_t      cnt;
  tick_t     tick_cnt;
  logic      tick;
  logic      cnt_ge_watermark;
  // LED path
  vled_t     hello_low;
  vled_t     vled_q;

  ocl_access_fsm u_access_fsm (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wready          (wready),
    .bready          (bready),
    .bvalid          (bvalid),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rready          (rready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .reg_wr_en       (reg_wr_en),
    .reg_wr_addr     (reg_wr_addr),
    .reg_wr_data     (reg_wr_data),
    .reg_rd_addr     (reg_rd_addr),
    .reg_rd_data     (reg_rd_data)
  );

  hello_reg_file u_reg_file (
    .clk_main_a0      (clk_main_a0),
    .rst_main_n_sync  (rst_main_n_sync),
    .reg_wr_en        (reg_wr_en),
    .reg_wr_addr      (reg_wr_addr),
    .reg_wr_data      (reg_wr_data),
    .reg_rd_addr      (reg_rd_addr),
    .reg_rd_data      (reg_rd_data),
    .cnt_enable       (cnt_enable),
    .cnt_oneshot      (cnt_oneshot),
    .cnt_load         (cnt_load),
    .cnt_clear        (cnt_clear),
    .tick_value       (tick_value),
    .load_value       (load_value),
    .watermark        (watermark),
    .cnt              (cnt),
    .tick_cnt         (tick_cnt),
    .tick             (tick),
    .cnt_ge_watermark (cnt_ge_watermark),
    .hello_low        (hello_low),
    .vled_q           (vled_q)
  );

  // Counter steered by the control registers
  event_counter u_event_counter (
    .clk_main_a0      (clk_main_a0),
    .rst_main_n_sync  (rst_main_n_sync),
    .cnt_enable       (cnt_enable),
    .cnt_oneshot      (cnt_oneshot),
    .cnt_load         (cnt_load),
    .cnt_clear        (cnt_clear),
    .tick_value       (tick_value),
    .load_value       (load_value),
    .watermark        (watermark),
    .cnt              (cnt),
    .tick_cnt         (tick_cnt),
    .tick             (tick),
    .cnt_ge_watermark (cnt_ge_watermark)
  );

  vled_mask u_vled_mask (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .hello_low       (hello_low),
    .status_vdip     (status_vdip),
    .vled_q          (vled_q),
    .status_vled     (status_vled)
  );

endmodule

`default_nettype wire

/* test/tb_clock_gen.sv */
// Testbench clock source and synchronous reset sequence
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk_main_a0,
  output logic rst_main_n_sync
);

  // 40 ns period
  localparam int HALF_PERIOD  = 20;
  localparam int RESET_CYCLES = 8;

  initial begin
    clk_main_a0 = 1'b0;
    forever begin
      #(HALF_PERIOD) clk_main_a0 = ~clk_main_a0;
    end
  end

  // Reset held low, released between rising edges
  initial begin
    rst_main_n_sync = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_main_a0);
    @(negedge clk_main_a0);
    rst_main_n_sync = 1'b1;
  end

endmodule

`default_nettype wire

/* test/tb_cl_hello.sv */
// Testbench top with bus tasks, register model, compare process, watchdog and summary
`timescale 1ns/1ps
`default_nettype none

`include "hello_config.svh"

module tb_cl_hello;

  // ----------------------------------------------------------------------
  // Run length and watchdog budget
  // ----------------------------------------------------------------------
  localparam int N_HELLO  = 8;
  localparam int N_VLED   = 3;
  localparam int N_BP     = 4;
  // Reset 2, settings 11, counter 13, running counter 6
  localparam int ACCESSES = 2 + 3 * N_HELLO + 11 + N_VLED + 13 + 6 + 2 * N_BP;
  // Reset, DIP settle, one-shot wait, run gap, back-pressure holds
  localparam int WAITS    = 10 + 7 * N_VLED + 100 + 100 + 20 * N_BP;
  localparam int WATCHDOG_CYCLES = 200 * ACCESSES + WAITS;

  localparam logic [31:0] CTRL_EN      = 32'h1 << `CTRL_ENABLE_BIT;
  localparam logic [31:0] CTRL_ONESHOT = 32'h1 << `CTRL_ONESHOT_BIT;
  localparam logic [31:0] CTRL_LOAD    = 32'h1 << `CTRL_LOAD_BIT;
  localparam logic [31:0] CTRL_CLEAR   = 32'h1 << `CTRL_CLEAR_BIT;

  logic        clk_main_a0;
  logic        rst_main_n_sync;
  // Bus
  logic        awvalid;
  logic [31:0] awaddr;
  logic        awready;
  logic        wvalid;
  logic [31:0] wdata;
  logic        wready;
  logic        bready;
  logic        bvalid;
  logic        arvalid;
  logic [31:0] araddr;
  logic        arready;
  logic        rready;
  logic        rvalid;
  logic [31:0] rdata;
  // Virtual switches and LEDs
  logic [15:0] status_vdip;
  logic [15:0] status_vled;

  integer      seed;
  int          errors;
  int          checks;
  int          tests;
  int          err_mark;
  int          cycle = 0;

  // Register map model
  logic [31:0] m_hello;
  logic        m_enable;
  logic        m_oneshot;
  logic [7:0]  m_tick_value;
  logic [15:0] m_load_value;
  logic [15:0] m_watermark;
  logic [15:0] m_cnt;
  logic [7:0]  m_tick_cnt;

  // Reads waiting for the compare process
  logic [31:0] addr_q[$];
  logic [31:0] exp_q[$];
  logic [31:0] got_q[$];
  event        read_seen;

  tb_clock_gen u_clock_gen (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync)
  );

  cl_hello_top i_dut (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wready          (wready),
    .bready          (bready),
    .bvalid          (bvalid),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rready          (rready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .status_vdip     (status_vdip),
    .status_vled     (status_vled)
  );

  always @(posedge clk_main_a0) begin
    cycle <= cycle + 1;
  end

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------
  // Expected read word for one address
  function automatic logic [31:0] ref_read(input logic [31:0] addr);
    logic [31:0] r;
    int          i;
    r = 32'h0;
    case (addr)
      `HELLO_WORLD_REG_ADDR: begin
        // Byte i of the read word is byte 3-i of the stored word
        for (i = 0; i < 4; i++) begin
          r[8*i +: 8] = m_hello[8*(3-i) +: 8];
        end
      end
      `VLED_REG_ADDR:       r[15:0] = m_hello[15:0];
      `CNT_CTRL_REG_ADDR: begin
        r[`CTRL_ENABLE_BIT]  = m_enable;
        r[`CTRL_ONESHOT_BIT] = m_oneshot;
      end
      `TICK_VALUE_REG_ADDR: r[7:0]  = m_tick_value;
      `LOAD_VALUE_REG_ADDR: r[15:0] = m_load_value;
      `WATERMARK_REG_ADDR:  r[15:0] = m_watermark;
      `CNT_STATUS_REG_ADDR: begin
        r[15:0]                       = m_cnt;
        r[`STATUS_TICK_CNT_LSB +: 8]  = m_tick_cnt;
        r[`STATUS_TICK_BIT]           = (m_tick_cnt >= m_tick_value);
        r[`STATUS_GE_WM_BIT]          = (m_cnt >= m_watermark);
      end
      default:              r = `UNIMPLEMENTED_REG_VALUE;
    endcase
    return r;
  endfunction

  // Model side effects of a bus write while the counter is stopped
  function automatic void model_write(input logic [31:0] addr, input logic [31:0] data);
    case (addr)
      `HELLO_WORLD_REG_ADDR: m_hello = data;
      `CNT_CTRL_REG_ADDR: begin
        m_enable  = data[`CTRL_ENABLE_BIT];
        m_oneshot = data[`CTRL_ONESHOT_BIT];
        // Clear wins over load
        if (data[`CTRL_CLEAR_BIT]) begin
          m_cnt      = 16'h0;
          m_tick_cnt = 8'h0;
        end else if (data[`CTRL_LOAD_BIT]) begin
          m_cnt = m_load_value;
        end
      end
      `TICK_VALUE_REG_ADDR: m_tick_value = data[7:0];
      `LOAD_VALUE_REG_ADDR: m_load_value = data[15:0];
      `WATERMARK_REG_ADDR:  m_watermark  = data[15:0];
      default: begin
      end
    endcase
  endfunction

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    assert (got === exp) else begin
      $display("FAILED t=%0t %s expected 0x%08h actual 0x%08h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1) else begin
      $display("ERROR t=%0t %s", $time, what);
      errors++;
    end
  endtask

  // One line per finished test
  task automatic end_test(input string name);
    // Let the compare process drain first
    @(negedge clk_main_a0);
    tests++;
    if (errors == err_mark) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      $display("test %0d %s: %0d errors", tests, name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  // ----------------------------------------------------------------------
  // Bus tasks driving inputs on the falling edge
  // ----------------------------------------------------------------------
  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data, input int hold);
    int i;
    @(negedge clk_main_a0);
    awvalid = 1'b1;
    awaddr  = addr;
    while (!awready) begin
      @(negedge clk_main_a0);
    end
    @(negedge clk_main_a0);
    awvalid = 1'b0;
    wvalid  = 1'b1;
    wdata   = data;
    // wready follows wvalid combinationally in the data phase
    wait (wready === 1'b1);
    @(negedge clk_main_a0);
    wvalid = 1'b0;
    bready = (hold == 0);
    while (!bvalid) begin
      @(negedge clk_main_a0);
    end
    // Response held back by the host
    for (i = 0; i < hold; i++) begin
      check_true(bvalid, "bvalid dropped before bready");
      check_true(!awready && !arready, "address accepted during write response");
      @(negedge clk_main_a0);
    end
    bready = 1'b1;
    @(negedge clk_main_a0);
    bready = 1'b0;
    check_true(!bvalid, "bvalid still high after the response was taken");
    model_write(addr, data);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data, input int hold);
    int i;
    @(negedge clk_main_a0);
    arvalid = 1'b1;
    araddr  = addr;
    while (!arready) begin
      @(negedge clk_main_a0);
    end
    @(negedge clk_main_a0);
    arvalid = 1'b0;
    rready  = (hold == 0);
    while (!rvalid) begin
      @(negedge clk_main_a0);
    end
    for (i = 0; i < hold; i++) begin
      check_true(rvalid, "rvalid dropped before rready");
      check_value("rdata", ref_read(addr), rdata);
      check_true(!awready && !arready, "address accepted during read response");
      @(negedge clk_main_a0);
    end
    data   = rdata;
    rready = 1'b1;
    @(negedge clk_main_a0);
    rready = 1'b0;
    check_true(!rvalid, "rvalid still high after the data was taken");
  endtask

  // Read and queue the word with its expected value
  task automatic read_check(input logic [31:0] addr, input int hold);
    logic [31:0] d;
    bus_read(addr, d, hold);
    addr_q.push_back(addr);
    exp_q.push_back(ref_read(addr));
    got_q.push_back(d);
    -> read_seen;
  endtask

  // Compare process
  initial begin : compare
    logic [31:0] a;
    logic [31:0] e;
    logic [31:0] g;
    forever begin
      @(read_seen);
      while (got_q.size() > 0) begin
        a = addr_q.pop_front();
        e = exp_q.pop_front();
        g = got_q.pop_front();
        check_value($sformatf("rdata@0x%08h", a), e, g);
      end
    end
  end

  // Watchdog
  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk_main_a0);
    $display("ERROR watchdog expired after %0d cycles, a handshake never completed",
             WATCHDOG_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------
  initial begin : stimulus
    logic [31:0] h;
    logic [31:0] r;
    logic [31:0] d1;
    logic [31:0] d2;
    int          c1;
    int          c2;
    int          hold;
    int          i;
    seed        = 32'h9f76;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    err_mark    = 0;
    awvalid     = 1'b0;
    awaddr      = 32'h0;
    wvalid      = 1'b0;
    wdata       = 32'h0;
    bready      = 1'b0;
    arvalid     = 1'b0;
    araddr      = 32'h0;
    rready      = 1'b0;
    status_vdip = 16'h0;
    // Model reset state
    m_hello      = 32'h0;
    m_enable     = 1'b0;
    m_oneshot    = 1'b0;
    m_tick_value = 8'h0;
    m_load_value = 16'h0;
    m_watermark  = 16'h0;
    m_cnt        = 16'h0;
    m_tick_cnt   = 8'h0;

    @(posedge rst_main_n_sync);
    @(negedge clk_main_a0);
    check_true(awready && arready, "address ready low after reset");
    check_true(!wready && !bvalid && !rvalid, "response or wready high after reset");
    check_value("rdata", 32'h0, rdata);
    check_value("status_vled", 32'h0, {16'h0, status_vled});
    read_check(`CNT_STATUS_REG_ADDR, 0);
    read_check(`CNT_CTRL_REG_ADDR, 0);
    end_test("reset");

    // Hello world readback
    for (i = 0; i < N_HELLO; i++) begin
      h = $random(seed);
      bus_write(`HELLO_WORLD_REG_ADDR, h, 0);
      read_check(`HELLO_WORLD_REG_ADDR, 0);
      read_check(`VLED_REG_ADDR, 0);
    end
    end_test("hello_swap");

    // Settings registers, pulse bits and unmapped reads
    r = $random(seed);
    bus_write(`TICK_VALUE_REG_ADDR, r, 0);
    r = $random(seed);
    bus_write(`LOAD_VALUE_REG_ADDR, r, 0);
    r = $random(seed);
    bus_write(`WATERMARK_REG_ADDR, r, 0);
    r = $random(seed);
    bus_write(`CNT_CTRL_REG_ADDR, (r & CTRL_ONESHOT) | CTRL_LOAD | CTRL_CLEAR, 0);
    read_check(`TICK_VALUE_REG_ADDR, 0);
    read_check(`LOAD_VALUE_REG_ADDR, 0);
    read_check(`WATERMARK_REG_ADDR, 0);
    read_check(`CNT_CTRL_REG_ADDR, 0);
    r = $random(seed);
    read_check(32'h0000_0600 + (r & 32'h0000_00FC), 0);
    read_check(32'h0000_051C, 0);
    read_check(32'hFFFF_FFFC, 0);
    end_test("settings");

    // Masked virtual LEDs
    for (i = 0; i < N_VLED; i++) begin
      h = $random(seed);
      bus_write(`HELLO_WORLD_REG_ADDR, h, 0);
      r = $random(seed);
      status_vdip = r[15:0];
      repeat (6) @(negedge clk_main_a0);
      check_value("status_vled", {16'h0, h[15:0] & r[15:0]}, {16'h0, status_vled});
    end
    end_test("vled_mask");

    // Counter load, clear and one-shot saturation
    bus_write(`CNT_CTRL_REG_ADDR, 32'h0, 0);
    r = $random(seed);
    bus_write(`LOAD_VALUE_REG_ADDR, r, 0);
    bus_write(`CNT_CTRL_REG_ADDR, CTRL_LOAD, 0);
    read_check(`CNT_STATUS_REG_ADDR, 0);
    bus_write(`CNT_CTRL_REG_ADDR, CTRL_CLEAR, 0);
    read_check(`CNT_STATUS_REG_ADDR, 0);
    bus_write(`TICK_VALUE_REG_ADDR, 32'h0, 0);
    bus_write(`WATERMARK_REG_ADDR, 32'h8000, 0);
    bus_write(`LOAD_VALUE_REG_ADDR, 32'hFFF0, 0);
    bus_write(`CNT_CTRL_REG_ADDR, CTRL_LOAD, 0);
    bus_write(`CNT_CTRL_REG_ADDR, CTRL_EN | CTRL_ONESHOT, 0);
    repeat (100) @(negedge clk_main_a0);
    // Tick value 0 wraps every cycle, so 15 steps reach all ones and hold
    m_cnt      = 16'hFFFF;
    m_tick_cnt = 8'h0;
    read_check(`CNT_STATUS_REG_ADDR, 0);
    read_check(`CNT_CTRL_REG_ADDR, 0);
    end_test("counter_oneshot");

    // Free-running counter steps once per four cycles
    bus_write(`CNT_CTRL_REG_ADDR, CTRL_CLEAR, 0);
    bus_write(`TICK_VALUE_REG_ADDR, 32'h3, 0);
    bus_write(`CNT_CTRL_REG_ADDR, CTRL_EN, 0);
    bus_read(`CNT_STATUS_REG_ADDR, d1, 0);
    c1 = cycle;
    r = $random(seed);
    repeat (60 + int'(r % 32'd40)) @(negedge clk_main_a0);
    bus_read(`CNT_STATUS_REG_ADDR, d2, 0);
    c2 = cycle;
    check_true(d2[15:0] >= d1[15:0], "counter value went down between status reads");
    check_true(({16'h0, d2[15:0]} - {16'h0, d1[15:0]}) <= ((c2 - c1) / 4 + 2),
               "counter advanced faster than the tick value allows");
    check_true(({16'h0, d2[15:0]} - {16'h0, d1[15:0]}) + 1 >= ((c2 - c1) / 4),
               "counter advanced slower than the tick value allows");
    bus_write(`CNT_CTRL_REG_ADDR, 32'h0, 0);
    end_test("counter_run");

    // Response back-pressure
    for (i = 0; i < N_BP; i++) begin
      h = $random(seed);
      r = $random(seed);
      hold = 1 + int'(r % 32'd10);
      bus_write(`HELLO_WORLD_REG_ADDR, h, hold);
      r = $random(seed);
      hold = 1 + int'(r % 32'd10);
      read_check(`HELLO_WORLD_REG_ADDR, hold);
    end
    end_test("backpressure");

    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+design
design/ocl_bus_pkg.sv
design/hello_regs_pkg.sv
design/ocl_access_fsm.sv
design/hello_reg_file.sv
design/event_counter.sv
design/vled_mask.sv
design/cl_hello_top.sv
test/tb_clock_gen.sv
test/tb_cl_hello.sv

/* Makefile */
# Verilator build and run for the hello register block testbench

SOURCES := $(filter-out +%,$(shell cat filelist.f)) design/hello_config.svh

.PHONY: all run clean

all: obj_dir/Vtb_cl_hello

obj_dir/Vtb_cl_hello: filelist.f $(SOURCES)
	verilator --binary --timing --assert -f filelist.f --top-module tb_cl_hello -o Vtb_cl_hello

# Passes only when the pass line shows up in the simulation output
run: obj_dir/Vtb_cl_hello
	@out="$$(./obj_dir/Vtb_cl_hello)"; echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf obj_dir
